/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run the regression"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --assert -Wno-fatal --top-module fir_serial_tb \
		-f fir_serial.f -Mdir obj_dir -o fir_serial_sim
	./obj_dir/fir_serial_sim

clean:
	rm -rf obj_dir

/* coef_ram.sv */
`timescale 1ns/1ps

module coef_ram #(
    parameter int MAX_TAPS = 32
) (
    input  logic                        clock,
    input  fir_pkg::coef_write_t        wr,
    input  logic [$clog2(MAX_TAPS)-1:0] rd_addr,
    output fir_pkg::sample_t            rd_data
);

    localparam int IDX_W = $clog2(MAX_TAPS);

    fir_pkg::sample_t mem [MAX_TAPS];

    logic addr_in_range;

    // Writes aimed past the last tap are dropped
    assign addr_in_range = 32'(wr.addr) < MAX_TAPS;

    always_ff @(posedge clock) begin
        if (wr.en && addr_in_range) begin
            mem[wr.addr[IDX_W-1:0]] <= wr.coef;
        end
    end

    // Registered read where data follows the address by one cycle
    always_ff @(posedge clock) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* fir_pkg.sv */
package fir_pkg;

    // Samples, coefficients and filter outputs all share this width
    localparam int DATA_WIDTH = 16;

    typedef logic signed [DATA_WIDTH-1:0] sample_t;

    // One coefficient write from the host in 25 bits
    typedef struct packed {
        logic    en;
        logic    [7:0] addr;
        sample_t coef;
    } coef_write_t;

    // Commands from the sequencer to the MAC unit
    typedef struct packed {
        logic clear;
        logic accumulate;
        logic emit;
    } mac_ctrl_t;

    // IDLE waits for a sample, RUN covers the tap pass, DRAIN issues the emit
    // and HOLD presents the result until it is taken
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RUN   = 2'd1,
        DRAIN = 2'd2,
        HOLD  = 2'd3
    } seq_state_t;

endpackage

/* fir_sequencer.sv */
`timescale 1ns/1ps

module fir_sequencer (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               in_valid,
    input  logic               out_ready,
    input  logic               busy,
    input  logic               last_tap,
    output logic               in_ready,
    output logic               sample_shift,
    output logic               start,
    output logic               out_valid,
    output fir_pkg::mac_ctrl_t mac_ctrl
);

    fir_pkg::seq_state_t state;
    fir_pkg::seq_state_t state_next;

    // Pulse in the cycle after acceptance that starts the counter and clears the sum
    logic kick;
    // Counter flags delayed by one cycle to match the memory read latency
    logic acc_dly;
    logic last_dly;

    assign in_ready  = state == fir_pkg::IDLE;
    assign out_valid = state == fir_pkg::HOLD;

    // The history captures in_data on the acceptance edge itself
    assign sample_shift = in_ready && in_valid;
    assign start        = kick;

    assign mac_ctrl.clear      = kick;
    assign mac_ctrl.accumulate = acc_dly;
    assign mac_ctrl.emit       = state == fir_pkg::DRAIN;

    always_comb begin
        state_next = state;
        case (state)
            fir_pkg::IDLE: begin
                if (in_valid) begin
                    state_next = fir_pkg::RUN;
                end
            end
            fir_pkg::RUN: begin
                // The final product is being added in this cycle
                if (last_dly) begin
                    state_next = fir_pkg::DRAIN;
                end
            end
            fir_pkg::DRAIN: begin
                state_next = fir_pkg::HOLD;
            end
            fir_pkg::HOLD: begin
                if (out_ready) begin
                    state_next = fir_pkg::IDLE;
                end
            end
            default: begin
                state_next = fir_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state    <= fir_pkg::IDLE;
            kick     <= 1'b0;
            acc_dly  <= 1'b0;
            last_dly <= 1'b0;
        end else begin
            state    <= state_next;
            kick     <= sample_shift;
            acc_dly  <= busy;
            last_dly <= last_tap;
        end
    end

endmodule

/* fir_serial.f */
fir_pkg.sv
coef_ram.sv
sample_history.sv
tap_counter.sv
fir_sequencer.sv
mac_unit.sv
fir_serial.sv
fir_serial_properties.sv
fir_serial_tb.sv

/* fir_serial.sv */
`timescale 1ns/1ps

module fir_serial #(
    parameter int MAX_TAPS  = 32,
    parameter int FRAC_BITS = 15
) (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 in_valid,
    input  fir_pkg::sample_t     in_data,
    output logic                 in_ready,
    output logic                 out_valid,
    input  logic                 out_ready,
    output fir_pkg::sample_t     out_data,
    input  fir_pkg::coef_write_t coef_wr,
    input  logic [7:0]           n_taps
);

    localparam int IDX_W = $clog2(MAX_TAPS);

    logic [IDX_W-1:0]   tap_index;
    logic               last_tap;
    logic               busy;
    logic               sample_shift;
    logic               start;
    fir_pkg::mac_ctrl_t mac_ctrl;
    fir_pkg::sample_t   coef_q;
    fir_pkg::sample_t   sample_q;

    fir_sequencer sequencer_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .out_ready    (out_ready),
        .busy         (busy),
        .last_tap     (last_tap),
        .in_ready     (in_ready),
        .sample_shift (sample_shift),
        .start        (start),
        .out_valid    (out_valid),
        .mac_ctrl     (mac_ctrl)
    );

    tap_counter #(.MAX_TAPS(MAX_TAPS)) tap_counter_i (
        .clock     (clock),
        .arst_n    (arst_n),
        .start     (start),
        .n_taps    (n_taps),
        .tap_index (tap_index),
        .last_tap  (last_tap),
        .busy      (busy)
    );

    // The same tap index addresses both memories, so their outputs pair up
    coef_ram #(.MAX_TAPS(MAX_TAPS)) coef_ram_i (
        .clock   (clock),
        .wr      (coef_wr),
        .rd_addr (tap_index),
        .rd_data (coef_q)
    );

    sample_history #(.MAX_TAPS(MAX_TAPS)) sample_history_i (
        .clock      (clock),
        .arst_n     (arst_n),
        .shift      (sample_shift),
        .new_sample (in_data),
        .rd_index   (tap_index),
        .rd_data    (sample_q)
    );

    mac_unit #(.FRAC_BITS(FRAC_BITS)) mac_unit_i (
        .clock  (clock),
        .arst_n (arst_n),
        .ctrl   (mac_ctrl),
        .coef   (coef_q),
        .sample (sample_q),
        .result (out_data)
    );

endmodule

/* fir_serial_properties.sv */
`timescale 1ns/1ps

module fir_serial_properties (
    input logic             clock,
    input logic             arst_n,
    input logic             in_ready,
    input logic             out_valid,
    input logic             out_ready,
    input fir_pkg::sample_t out_data
);

    // A presented result waits unchanged until the consumer takes it
    out_hold_a: assert property (
        @(posedge clock) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    ) else $error("out_data changed or out_valid dropped while the output was stalled");

    // No new sample is taken while a result is still waiting
    ready_excl_a: assert property (
        @(posedge clock) disable iff (!arst_n)
        !(in_ready && out_valid)
    ) else $error("in_ready and out_valid were high in the same cycle");

endmodule

bind fir_serial fir_serial_properties fir_serial_properties_i (
    .clock     (clock),
    .arst_n    (arst_n),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
);

/* fir_serial_tb.sv */
`timescale 1ns/1ps

module fir_serial_tb;

    localparam int MAX_TAPS        = 32;
    localparam int FRAC_BITS       = 15;
    localparam int CLK_PERIOD      = 40;
    localparam int WATCHDOG_CYCLES = 400 * (MAX_TAPS + 6) + 2000;

    // Stimulus patterns for samples and coefficients
    localparam int RANDOM     = 0;
    localparam int IMPULSE    = 1;
    localparam int FULL_SCALE = 2;

    logic                 clock;
    logic                 arst_n;
    logic                 in_valid;
    fir_pkg::sample_t     in_data;
    logic                 in_ready;
    logic                 out_valid;
    logic                 out_ready;
    fir_pkg::sample_t     out_data;
    fir_pkg::coef_write_t coef_wr;
    logic [7:0]           n_taps;

    // Reference model state
    fir_pkg::sample_t coef_model [MAX_TAPS];
    fir_pkg::sample_t hist_model [MAX_TAPS];
    fir_pkg::sample_t expected_q [$];
    int               ready_pct;
    logic             stalled;
    fir_pkg::sample_t held_data;

    fir_serial #(.MAX_TAPS(MAX_TAPS), .FRAC_BITS(FRAC_BITS)) fir_serial_i (
        .clock     (clock),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .coef_wr   (coef_wr),
        .n_taps    (n_taps)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "Stopping at the first error");
    endtask

    function automatic void clear_history_model();
        for (int k = 0; k < MAX_TAPS; k++) begin
            hist_model[k] = '0;
        end
    endfunction

    // Sum of coefficient k times the sample taken k samples ago
    function automatic fir_pkg::sample_t expected_output();
        longint sum;
        longint scaled;
        sum = 0;
        for (int k = 0; k < int'(n_taps); k++) begin
            sum += longint'(coef_model[k]) * longint'(hist_model[k]);
        end
        scaled = sum >>> FRAC_BITS;
        if (scaled > 32767) begin
            return 16'sh7fff;
        end else if (scaled < -32768) begin
            return 16'sh8000;
        end
        return fir_pkg::sample_t'(scaled);
    endfunction

    function automatic fir_pkg::sample_t pick_sample(input int kind, input int index);
        case (kind)
            IMPULSE:    return (index == 0) ? 16'sh7fff : 16'sh0000;
            FULL_SCALE: return $urandom_range(1) ? 16'sh7fff : 16'sh8000;
            default:    return fir_pkg::sample_t'($urandom);
        endcase
    endfunction

    function automatic fir_pkg::sample_t pick_coef(input int kind);
        int mag;
        if (kind != FULL_SCALE) begin
            return fir_pkg::sample_t'($urandom);
        end
        // Large magnitudes of either sign push the sum past the 16-bit range
        mag = int'($urandom_range(32767, 24576));
        return $urandom_range(1) ? fir_pkg::sample_t'(mag) : fir_pkg::sample_t'(-mag);
    endfunction

    // Runs at every rising edge on the values that held just before it
    task automatic check_handshakes();
        fir_pkg::sample_t expected;
        assert (!(in_ready && out_valid)) else begin
            abort_run("in_ready and out_valid were high in the same cycle");
        end
        if (stalled) begin
            assert (out_valid && out_data == held_data) else begin
                abort_run("out_valid dropped or out_data changed while the output was stalled");
            end
        end
        if (out_valid && out_ready) begin
            assert (expected_q.size() > 0) else begin
                abort_run("A result was taken with no sample pending");
            end
            expected = expected_q.pop_front();
            assert (out_data == expected) else begin
                abort_run($sformatf("[FAIL] out_data = 0x%04h, expected 0x%04h",
                                    out_data, expected));
            end
        end
        if (in_valid && in_ready) begin
            for (int k = MAX_TAPS - 1; k > 0; k--) begin
                hist_model[k] = hist_model[k-1];
            end
            hist_model[0] = in_data;
            expected_q.push_back(expected_output());
        end
        stalled   = out_valid && !out_ready;
        held_data = out_data;
    endtask

    task automatic step();
        @(posedge clock);
        if (!arst_n) begin
            stalled = 1'b0;
        end else begin
            check_handshakes();
        end
        out_ready <= ($urandom_range(99) < ready_pct);
    endtask

    task automatic load_coefs(input int kind);
        fir_pkg::coef_write_t wr;
        step();
        assert (in_ready) else begin
            abort_run("Coefficient load attempted while the filter was busy");
        end
        wr.en = 1'b1;
        for (int i = 0; i < MAX_TAPS; i++) begin
            wr.addr = 8'(i);
            wr.coef = pick_coef(kind);
            coef_wr <= wr;
            coef_model[i] = wr.coef;
            step();
        end
        // Past the last tap, so the memory must not change
        wr.addr = 8'(MAX_TAPS + $urandom_range(200));
        wr.coef = fir_pkg::sample_t'($urandom);
        coef_wr <= wr;
        step();
        coef_wr <= '0;
    endtask

    task automatic set_taps(input logic [7:0] count);
        step();
        n_taps <= count;
    endtask

    // A pending sample keeps its data until the DUT takes it
    task automatic stream_samples(input int count, input int kind, input int gap_pct);
        int sent;
        sent = 0;
        while (sent < count) begin
            step();
            if (in_valid && in_ready) begin
                sent++;
            end
            if (!in_valid || in_ready) begin
                if (sent < count && $urandom_range(99) >= gap_pct) begin
                    in_valid <= 1'b1;
                    in_data  <= pick_sample(kind, sent);
                end else begin
                    in_valid <= 1'b0;
                end
            end
        end
    endtask

    task automatic wait_drained();
        while (expected_q.size() != 0) begin
            step();
        end
    endtask

    task automatic reset_mid_pass();
        step();
        in_valid <= 1'b1;
        in_data  <= fir_pkg::sample_t'($urandom);
        step();
        while (!(in_valid && in_ready)) begin
            step();
        end
        in_valid <= 1'b0;
        repeat (5) step();
        assert (!in_ready) else begin
            abort_run("The filter was not busy when the mid-run reset was applied");
        end
        arst_n <= 1'b0;
        step();
        // The sample in flight is lost along with the history
        expected_q.delete();
        clear_history_model();
        repeat (3) step();
        assert (in_ready && !out_valid) else begin
            abort_run("in_ready was low or out_valid high while reset was held");
        end
        arst_n <= 1'b1;
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("Watchdog expired before all results were taken");
    end

    initial begin
        void'($urandom(32'h0d73_84c3));
        clock          = 1'b0;
        arst_n         = 1'b0;
        in_valid       = 1'b0;
        in_data        = '0;
        out_ready      = 1'b0;
        coef_wr        = '0;
        n_taps         = 8'd32;
        ready_pct      = 100;
        stalled        = 1'b0;
        held_data      = '0;
        clear_history_model();
        repeat (10) step();
        arst_n <= 1'b1;

        // Impulse on an empty history returns the scaled coefficients in order
        load_coefs(RANDOM);
        stream_samples(MAX_TAPS + 1, IMPULSE, 0);
        wait_drained();

        // History carries over each change of tap count
        load_coefs(RANDOM);
        set_taps(8'd1);
        stream_samples(50, RANDOM, 20);
        wait_drained();
        set_taps(8'd7);
        stream_samples(50, RANDOM, 20);
        wait_drained();
        set_taps(8'd32);
        stream_samples(40, RANDOM, 20);
        wait_drained();

        load_coefs(FULL_SCALE);
        stream_samples(40, FULL_SCALE, 20);
        wait_drained();

        // Back-pressure with gaps on both streams
        load_coefs(RANDOM);
        set_taps(8'd7);
        ready_pct = 30;
        stream_samples(60, RANDOM, 50);
        wait_drained();
        ready_pct = 100;

        set_taps(8'd32);
        reset_mid_pass();
        stream_samples(30, RANDOM, 10);
        wait_drained();

        // Once every sample is answered the filter stays idle with nothing to present
        repeat (MAX_TAPS + 4) step();
        assert (in_ready && !out_valid) else begin
            abort_run("A result appeared after every accepted sample was answered");
        end

        $display("Regression passed");
        $finish;
    end

endmodule

/* mac_unit.sv */
`timescale 1ns/1ps

module mac_unit #(
    parameter int FRAC_BITS = 15
) (
    input  logic               clock,
    input  logic               arst_n,
    input  fir_pkg::mac_ctrl_t ctrl,
    input  fir_pkg::sample_t   coef,
    input  fir_pkg::sample_t   sample,
    output fir_pkg::sample_t   result
);

    localparam int DW    = fir_pkg::DATA_WIDTH;
    localparam int ACC_W = 2 * DW + 8;

    logic signed [2*DW-1:0]  product;
    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] scaled;
    logic                    fits;
    fir_pkg::sample_t        clamped;

    assign product = coef * sample;

    // The shift truncates, so the low fraction bits are simply dropped
    assign scaled = acc >>> FRAC_BITS;

    // The value fits when every bit above the sample sign bit copies that sign bit
    assign fits = (scaled[ACC_W-1:DW-1] == '0) || (scaled[ACC_W-1:DW-1] == '1);

    always_comb begin
        if (fits) begin
            clamped = scaled[DW-1:0];
        end else if (scaled[ACC_W-1]) begin
            clamped = {1'b1, {(DW-1){1'b0}}};
        end else begin
            clamped = {1'b0, {(DW-1){1'b1}}};
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            acc <= '0;
        end else if (ctrl.clear) begin
            acc <= '0;
        end else if (ctrl.accumulate) begin
            acc <= acc + product;
        end
    end

    // Result stays put until the next emit, which holds out_data under stall
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else if (ctrl.emit) begin
            result <= clamped;
        end
    end

endmodule

/* sample_history.sv */
`timescale 1ns/1ps

module sample_history #(
    parameter int MAX_TAPS = 32
) (
    input  logic                        clock,
    input  logic                        arst_n,
    input  logic                        shift,
    input  fir_pkg::sample_t            new_sample,
    input  logic [$clog2(MAX_TAPS)-1:0] rd_index,
    output fir_pkg::sample_t            rd_data
);

    fir_pkg::sample_t hist [MAX_TAPS];

    // Entry 0 holds the newest sample and older samples move up by one per shift
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < MAX_TAPS; i++) begin
                hist[i] <= '0;
            end
        end else if (shift) begin
            hist[0] <= new_sample;
            for (int i = 1; i < MAX_TAPS; i++) begin
                hist[i] <= hist[i-1];
            end
        end
    end

    // Read port lines up with the coefficient memory latency
    always_ff @(posedge clock) begin
        rd_data <= hist[rd_index];
    end

endmodule

/* tap_counter.sv */
`timescale 1ns/1ps

module tap_counter #(
    parameter int MAX_TAPS = 32
) (
    input  logic                        clock,
    input  logic                        arst_n,
    input  logic                        start,
    input  logic [7:0]                  n_taps,
    output logic [$clog2(MAX_TAPS)-1:0] tap_index,
    output logic                        last_tap,
    output logic                        busy
);

    logic [7:0] last_index;
    logic [7:0] index_ext;

    assign last_index = n_taps - 8'd1;
    assign index_ext  = 8'(tap_index);

    // Only meaningful while counting
    assign last_tap = busy && (index_ext == last_index);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            tap_index <= '0;
            busy      <= 1'b0;
        end else if (start) begin
            tap_index <= '0;
            busy      <= 1'b1;
        end else if (busy) begin
            if (last_tap) begin
                busy <= 1'b0;
            end else begin
                tap_index <= tap_index + 1'b1;
            end
        end
    end

endmodule
